/* design/residue_pkg.sv */
package residue_pkg;

  localparam int unsigned modulus = 113;
  localparam int unsigned fold_weight = 15;  // 2^7 mod 113

  typedef logic [6:0] residue_t;  // always holds 0 to 112 at a module boundary
  typedef logic [5:0] chunk_t;
  typedef logic [10:0] partial_t;  // up to eighteen chunk residues before folding

  // weight of the chunk at a given index, 2^(6*index) mod 113
  function automatic int unsigned chunk_weight(input int unsigned index);
    int unsigned w;
    w = 1;
    for (int unsigned i = 0; i < index; i++)
    begin
      w = (w * 64) % modulus;
    end
    return w;
  endfunction

  // residue of 2^width, the factor that moves the running residue past one word
  function automatic int unsigned shift_residue(input int unsigned width);
    int unsigned w;
    w = 1;
    for (int unsigned i = 0; i < width; i++)
    begin
      w = (w * 2) % modulus;
    end
    return w;
  endfunction

endpackage

/* design/stream_pkg.sv */
package stream_pkg;

  localparam int unsigned beat_data_w = 200;  // default operand width of the engine

  typedef struct packed {
    logic [beat_data_w-1:0] data;
    logic                   first;
    logic                   last;
  } word_beat_t;

  // one word's residue, still carrying the message framing
  typedef struct packed {
    residue_pkg::residue_t residue;
    logic                  first;
    logic                  last;
  } reduced_word_t;

  typedef struct packed {
    residue_pkg::residue_t residue;
  } message_result_t;

endpackage

/* design/chunk_residue.sv */
module chunk_residue #(
  parameter int unsigned chunk_idx = 0
) (
  input  residue_pkg::chunk_t   chunk,
  output residue_pkg::residue_t residue
);

  localparam int unsigned weight = residue_pkg::chunk_weight(chunk_idx);
  localparam int unsigned entry_w = $bits(residue_pkg::residue_t);
  localparam int unsigned entries = 2 ** $bits(residue_pkg::chunk_t);

  // entry c holds (c * weight) mod 113, packed lowest entry first
  function automatic logic [entries*entry_w-1:0] build_table();
    logic [entries*entry_w-1:0] t;
    t = '0;
    for (int unsigned c = 0; c < entries; c++)
    begin
      t[c*entry_w +: entry_w] = residue_pkg::residue_t'((c * weight) % residue_pkg::modulus);
    end
    return t;
  endfunction

  localparam logic [entries*entry_w-1:0] lut = build_table();

  assign residue = lut[chunk*entry_w +: entry_w];  // plain ROM lookup, no arithmetic left

endmodule

/* design/operand_reducer.sv */
module operand_reducer #(
  parameter int unsigned operand_w = 200
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      beat_valid,
  input  stream_pkg::word_beat_t    beat,
  output logic                      red_valid,
  output stream_pkg::reduced_word_t red
);

  localparam int unsigned n_chunks = (operand_w + 5) / 6;
  localparam int unsigned op_pad_w = n_chunks * 6;
  // eighteen residues of at most 112 stay below 2048 and fit a partial_t
  localparam int unsigned n_parts = (n_chunks + 17) / 18;
  localparam int unsigned n_slots = n_parts * 18;
  localparam int unsigned n_triples = n_parts * 6;
  localparam int unsigned fold_w = $clog2(n_parts * 352 + 1);

  logic [op_pad_w-1:0]   operand;
  residue_pkg::residue_t chunk_res [n_slots];
  residue_pkg::residue_t chunk_res_q [n_slots];
  logic                  valid_q;
  logic                  first_q;
  logic                  last_q;
  logic [8:0]            triple_sum [n_triples];
  residue_pkg::partial_t part_sum [n_parts];
  logic [fold_w-1:0]     fold_sum;
  logic [fold_w-1:0]     refold;
  residue_pkg::residue_t word_res;

  // 128 = 15 (mod 113), so bits from 7 upward are worth 15 each step
  function automatic logic [8:0] fold_partial(input residue_pkg::partial_t v);
    return 9'(v[5:0]) + 9'({v[6], 6'b0}) + 9'(v[10:7]) * 9'(residue_pkg::fold_weight);
  endfunction

  assign operand = op_pad_w'(beat.data[operand_w-1:0]);  // top chunk is zero padded

  for (genvar i = 0; i < n_slots; i++)
  begin : g_chunk
    if (i < n_chunks)
    begin : g_map
      chunk_residue #(
        .chunk_idx(i)
      ) chunk_residue_i (
        .chunk  (operand[i*6 +: 6]),
        .residue(chunk_res[i])
      );
    end
    else
    begin : g_pad
      assign chunk_res[i] = '0;
    end
  end

  // stage 1 holds every chunk residue of the accepted word
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= beat_valid;
  end

  always_ff @(posedge clk)
  begin
    if (beat_valid)
    begin
      chunk_res_q <= chunk_res;
      first_q <= beat.first;
      last_q <= beat.last;
    end
  end

  always_comb
  begin
    for (int t = 0; t < n_triples; t++)
    begin
      triple_sum[t] = 9'(chunk_res_q[3*t]) + 9'(chunk_res_q[3*t+1]) + 9'(chunk_res_q[3*t+2]);
    end

    for (int p = 0; p < n_parts; p++)
    begin
      part_sum[p] = '0;
      for (int k = 0; k < 6; k++)
      begin
        part_sum[p] = part_sum[p] + residue_pkg::partial_t'(triple_sum[6*p+k]);
      end
    end

    fold_sum = '0;
    for (int p = 0; p < n_parts; p++)
    begin
      fold_sum = fold_sum + fold_w'(fold_partial(part_sum[p]));
    end

    // second fold brings the value under 226, so a single subtract finishes it
    refold = fold_w'(fold_sum[5:0]) + fold_w'({fold_sum[6], 6'b0})
           + fold_w'(fold_sum[fold_w-1:7]) * fold_w'(residue_pkg::fold_weight);

    if (refold >= fold_w'(residue_pkg::modulus))
      word_res = residue_pkg::residue_t'(refold - fold_w'(residue_pkg::modulus));
    else
      word_res = residue_pkg::residue_t'(refold);
  end

  // stage 2 presents the reduced word
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      red_valid <= 1'b0;
    else
      red_valid <= valid_q;
  end

  always_ff @(posedge clk)
  begin
    if (valid_q)
      red <= '{residue: word_res, first: first_q, last: last_q};
  end

endmodule

/* design/message_accumulator.sv */
module message_accumulator #(
  parameter int unsigned operand_w = 200
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        red_valid,
  input  stream_pkg::reduced_word_t   red,
  output logic                        result_valid,
  output stream_pkg::message_result_t result
);

  localparam int unsigned word_shift = residue_pkg::shift_residue(operand_w);

  residue_pkg::residue_t acc_q;
  residue_pkg::residue_t acc_next;
  logic [13:0]           product;
  logic [13:0]           fold_1;
  logic [13:0]           fold_2;
  logic [13:0]           fold_3;

  // one step of the 128 = 15 (mod 113) fold on a 14-bit value
  function automatic logic [13:0] fold15(input logic [13:0] v);
    return 14'(v[6:0]) + 14'(v[13:7]) * 14'(residue_pkg::fold_weight);
  endfunction

  // an earlier word moves up by one operand width, so it is scaled by 2^operand_w
  assign product = 14'(acc_q) * 14'(word_shift) + 14'(red.residue);

  // three folds take the sum from under 12657 down to under 158
  assign fold_1 = fold15(product);
  assign fold_2 = fold15(fold_1);
  assign fold_3 = fold15(fold_2);

  always_comb
  begin
    if (red.first)
      acc_next = red.residue;  // a new message ignores whatever came before
    else if (fold_3 >= 14'(residue_pkg::modulus))
      acc_next = residue_pkg::residue_t'(fold_3 - 14'(residue_pkg::modulus));
    else
      acc_next = residue_pkg::residue_t'(fold_3);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      acc_q <= '0;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= red_valid && red.last;
      if (red_valid)
        acc_q <= acc_next;
    end
  end

  // the register already holds the message residue on the result cycle
  assign result = '{residue: acc_q};

endmodule

/* design/residue_engine.sv */
module residue_engine #(
  parameter int unsigned operand_w = 200
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        beat_valid,
  input  stream_pkg::word_beat_t      beat,
  output logic                        result_valid,
  output stream_pkg::message_result_t result
);

  logic                      red_valid;
  stream_pkg::reduced_word_t red;

  // two cycles to reduce one word
  operand_reducer #(
    .operand_w(operand_w)
  ) reducer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .beat_valid(beat_valid),
    .beat      (beat),
    .red_valid (red_valid),
    .red       (red)
  );

  // one more cycle to fold the word into its message
  message_accumulator #(
    .operand_w(operand_w)
  ) accumulator_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .red_valid   (red_valid),
    .red         (red),
    .result_valid(result_valid),
    .result      (result)
  );

endmodule

/* dv/residue_engine_sva.sv */
module residue_engine_sva (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        beat_valid,
  input stream_pkg::word_beat_t      beat,
  input logic                        result_valid,
  input stream_pkg::message_result_t result
);

  timeunit 1ns;
  timeprecision 100ps;

  // the registers clear on the first reset edge, so look one cycle later
  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !result_valid)
    else $error("result_valid high while rst_n was low");

  a_residue_range: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> (result.residue < 7'(residue_pkg::modulus)))
    else $error("result residue is not below the modulus");

  // two reducer stages plus the accumulator register
  a_last_to_result: assert property (@(posedge clk) disable iff (!rst_n)
    (beat_valid && beat.last) |-> ##3 result_valid)
    else $error("no result three cycles after a last beat");

  a_result_has_last: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> $past(beat_valid && beat.last, 3))
    else $error("result without a last beat three cycles before");

endmodule

bind residue_engine residue_engine_sva sva_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .beat_valid  (beat_valid),
  .beat        (beat),
  .result_valid(result_valid),
  .result      (result)
);

/* dv/residue_engine_tb.sv */
module residue_engine_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned word_w = stream_pkg::beat_data_w;
  localparam int max_words = 6;
  localparam int drain_timeout = 50;
  localparam int latency = 3;  // falling edges from a visible last beat to its result

  typedef logic [word_w-1:0] word_t;

  logic                        clk;
  logic                        rst_n;
  logic                        beat_valid;
  stream_pkg::word_beat_t      beat;
  logic                        result_valid;
  stream_pkg::message_result_t result;

  residue_pkg::residue_t exp_res_q [$];
  int                    due_cycle_q [$];
  int                    exp_total;
  int                    got_total;
  int                    cyc;
  logic [31:0]           rng_state;

  residue_engine #(
    .operand_w(word_w)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .result_valid(result_valid),
    .result      (result)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_residue(input residue_pkg::residue_t got,
                               input residue_pkg::residue_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("MISMATCH result.residue: got 0x%0h, expected 0x%0h",
                                  got, exp));
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp)
      stop_with_failure($sformatf("MISMATCH result_valid cycle: got 0x%0h, expected 0x%0h",
                                  got, exp));
  endtask

  task automatic check_result_count(input int got, input int exp);
    if (got != exp)
      stop_with_failure($sformatf("MISMATCH result count: got 0x%0h, expected 0x%0h",
                                  got, exp));
  endtask

  function automatic logic [31:0] advance_rng(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t random_word();
    logic [7*32-1:0] bits;
    for (int i = 0; i < 7; i++)
    begin
      rng_state = advance_rng(rng_state);
      bits[i*32 +: 32] = rng_state;
    end
    return bits[word_w-1:0];
  endfunction

  // shift the whole message in one bit at a time, first word on top
  function automatic residue_pkg::residue_t ref_residue(input word_t words [max_words],
                                                         input int n_words);
    int unsigned r;
    r = 0;
    for (int w = 0; w < n_words; w++)
      for (int b = word_w - 1; b >= 0; b--)
        r = (2 * r + words[w][b]) % residue_pkg::modulus;
    return residue_pkg::residue_t'(r);
  endfunction

  task automatic drive_idle();
    beat_valid = 1'b0;
    beat = '0;
  endtask

  // called 1 ns after a rising edge and returns at the same point one cycle on
  task automatic send_beat(input word_t data, input logic first, input logic last);
    beat_valid = 1'b1;
    beat.data = data;
    beat.first = first;
    beat.last = last;
    @(posedge clk);
    #1;
  endtask

  task automatic send_message(input word_t words [max_words], input int n_words);
    exp_res_q.push_back(ref_residue(words, n_words));
    exp_total++;
    for (int w = 0; w < n_words; w++)
      send_beat(words[w], w == 0, w == n_words - 1);
    drive_idle();
  endtask

  task automatic send_single(input word_t data);
    word_t words [max_words];
    for (int w = 0; w < max_words; w++)
      words[w] = '0;
    words[0] = data;
    send_message(words, 1);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_res_q.size() != 0)
    begin
      if (waited == drain_timeout)
        stop_with_failure("timeout: results still outstanding after 50 cycles");
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  // outputs are sampled on the falling edge where they are settled
  initial
  begin
    cyc = 0;
    got_total = 0;
    forever
    begin
      @(negedge clk);
      cyc++;
      if (rst_n && beat_valid && beat.last)
        due_cycle_q.push_back(cyc + latency);
      if (result_valid === 1'b1)
      begin
        if (exp_res_q.size() == 0 || due_cycle_q.size() == 0)
          stop_with_failure("result_valid pulsed with no message outstanding");
        check_latency(cyc, due_cycle_q.pop_front());
        check_residue(result.residue, exp_res_q.pop_front());
        got_total++;
      end
      else if (due_cycle_q.size() != 0 && due_cycle_q[0] <= cyc)
        stop_with_failure("result_valid missing three cycles after a last beat");
    end
  end

  initial
  begin
    word_t words [max_words];
    int    n_words;
    rng_state = 32'h493a;
    exp_total = 0;
    rst_n = 1'b0;
    drive_idle();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // nothing sent yet, so the output has to stay quiet
    for (int c = 0; c < 20; c++)
    begin
      @(posedge clk);
      #1;
      if (result_valid !== 1'b0)
        stop_with_failure("result_valid rose after reset with no beats driven");
    end

    send_single('0);
    send_single('1);
    send_single(word_t'(113));
    send_single(word_t'(112));
    for (int b = 0; b < word_w; b += 6)
      send_single(word_t'(1) << b);  // one bit at the bottom of every chunk
    wait_drained();

    // back to back, so up to three words are in flight at once
    for (int m = 0; m < 200; m++)
      send_single(random_word());
    wait_drained();

    for (int m = 0; m < 40; m++)
    begin
      rng_state = advance_rng(rng_state);
      n_words = 2 + int'(rng_state % 5);
      for (int w = 0; w < max_words; w++)
        words[w] = (w < n_words) ? random_word() : '0;
      send_message(words, n_words);
    end
    wait_drained();

    repeat (5) @(posedge clk);
    check_result_count(got_total, exp_total);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* project.f */
design/residue_pkg.sv
design/stream_pkg.sv
design/chunk_residue.sv
design/operand_reducer.sv
design/message_accumulator.sv
design/residue_engine.sv
dv/residue_engine_sva.sv
dv/residue_engine_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module residue_engine_tb -f project.f \
  -o residue_engine_sim || exit 1
sim_out=$(./obj_dir/residue_engine_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation finished: PASS" && exit 0 || exit 1
